/* hdl/decode_pkg.sv */
package decode_pkg;

  localparam int LANES = 2;
  localparam int UOPS_PER_INSN = 2;
  localparam int SLOTS = LANES * UOPS_PER_INSN; // every lane cracked

  typedef logic [31:0] insn_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [20:0] imm_t;
  typedef logic [63:0] addr_t;
  typedef logic [1:0] slot_idx_t;

  // opcode prefixes, matched against the top bits of the word
  localparam logic [9:0] ENC_ADD_IMM = 10'b1001000100;
  localparam logic [9:0] ENC_SUB_IMM = 10'b1101000100;
  localparam logic [10:0] ENC_ADDS = 11'b10101011000;
  localparam logic [10:0] ENC_SUBS = 11'b11101011000; // also cmp
  localparam logic [10:0] ENC_ORR = 11'b10101010000;
  localparam logic [10:0] ENC_EOR = 11'b11001010000;
  localparam logic [10:0] ENC_ANDS = 11'b11101010000; // also tst
  localparam logic [8:0] ENC_MOVZ = 9'b110100101;
  localparam logic [8:0] ENC_MOVK = 9'b111100101;
  localparam logic [10:0] ENC_LDUR = 11'b11111000010;
  localparam logic [10:0] ENC_STUR = 11'b11111000000;
  localparam logic [5:0] ENC_B = 6'b000101;
  localparam logic [10:0] ENC_HLT = 11'b11010100010;
  localparam insn_t ENC_NOP = 32'hd503201f;

  typedef enum logic [2:0] {
    CLS_NONE,
    CLS_ALU_IMM,
    CLS_ALU_REG,
    CLS_MOVE,
    CLS_MEM,
    CLS_BRANCH,
    CLS_HLT
  } insn_class_e;

  typedef enum logic [3:0] {
    UOP_NOP = 4'd0,
    UOP_ADD,
    UOP_SUB,
    UOP_AND,
    UOP_ORR,
    UOP_EOR,
    UOP_MOVZ,
    UOP_MOVK,
    UOP_LOAD,
    UOP_STORE,
    UOP_HLT
  } uop_op_e;

  typedef enum logic {
    SKID_EMPTY,
    SKID_HELD
  } skid_state_e;

endpackage

/* hdl/insn_classify.sv */
`timescale 1ns/10ps

module insn_classify (
  input  decode_pkg::insn_t       insn,
  output decode_pkg::insn_class_e insn_class,
  output decode_pkg::uop_op_e     uop_code
);

  logic add_imm, sub_imm;
  logic adds, subs, orr, eor, ands;
  logic movz, movk, ldur, stur;

  assign add_imm = insn[31:22] == decode_pkg::ENC_ADD_IMM;
  assign sub_imm = insn[31:22] == decode_pkg::ENC_SUB_IMM;
  assign adds = insn[31:21] == decode_pkg::ENC_ADDS;
  assign subs = insn[31:21] == decode_pkg::ENC_SUBS;
  assign orr = insn[31:21] == decode_pkg::ENC_ORR;
  assign eor = insn[31:21] == decode_pkg::ENC_EOR;
  assign ands = insn[31:21] == decode_pkg::ENC_ANDS;
  assign movz = insn[31:23] == decode_pkg::ENC_MOVZ;
  assign movk = insn[31:23] == decode_pkg::ENC_MOVK;
  assign ldur = insn[31:21] == decode_pkg::ENC_LDUR;
  assign stur = insn[31:21] == decode_pkg::ENC_STUR;

  always_comb begin
    insn_class = decode_pkg::CLS_NONE;
    uop_code = decode_pkg::UOP_NOP;
    if (insn == decode_pkg::ENC_NOP) begin
      insn_class = decode_pkg::CLS_NONE; // hint, emits nothing
    end else if (add_imm || sub_imm) begin
      insn_class = decode_pkg::CLS_ALU_IMM;
      uop_code = sub_imm ? decode_pkg::UOP_SUB : decode_pkg::UOP_ADD;
    end else if (adds || subs || orr || eor || ands) begin
      insn_class = decode_pkg::CLS_ALU_REG;
      uop_code = adds ? decode_pkg::UOP_ADD :
                 subs ? decode_pkg::UOP_SUB :
                 orr  ? decode_pkg::UOP_ORR :
                 eor  ? decode_pkg::UOP_EOR : decode_pkg::UOP_AND;
    end else if (movz || movk) begin
      insn_class = decode_pkg::CLS_MOVE;
      uop_code = movk ? decode_pkg::UOP_MOVK : decode_pkg::UOP_MOVZ;
    end else if (ldur || stur) begin
      insn_class = decode_pkg::CLS_MEM;
      uop_code = ldur ? decode_pkg::UOP_LOAD : decode_pkg::UOP_STORE;
    end else if (insn[31:26] == decode_pkg::ENC_B) begin
      insn_class = decode_pkg::CLS_BRANCH; // resolved in fetch
    end else if (insn[31:21] == decode_pkg::ENC_HLT) begin
      insn_class = decode_pkg::CLS_HLT;
      uop_code = decode_pkg::UOP_HLT;
    end
  end

endmodule

/* hdl/insn_lane_decode.sv */
`timescale 1ns/10ps

module insn_lane_decode (
  input  decode_pkg::insn_t    insn,
  input  decode_pkg::addr_t    pc,
  output logic [1:0]           uop_count,
  output logic                 stop,
  output decode_pkg::uop_op_e  op        [decode_pkg::UOPS_PER_INSN],
  output decode_pkg::reg_idx_t dst       [decode_pkg::UOPS_PER_INSN],
  output decode_pkg::reg_idx_t src1      [decode_pkg::UOPS_PER_INSN],
  output decode_pkg::reg_idx_t src2      [decode_pkg::UOPS_PER_INSN],
  output decode_pkg::imm_t     imm       [decode_pkg::UOPS_PER_INSN],
  output logic                 valb_sel  [decode_pkg::UOPS_PER_INSN],
  output logic                 mem_read  [decode_pkg::UOPS_PER_INSN],
  output logic                 mem_write [decode_pkg::UOPS_PER_INSN],
  output logic                 w_enable  [decode_pkg::UOPS_PER_INSN],
  output logic                 tx_begin  [decode_pkg::UOPS_PER_INSN],
  output logic                 tx_end    [decode_pkg::UOPS_PER_INSN],
  output decode_pkg::addr_t    pc_out    [decode_pkg::UOPS_PER_INSN]
);

  decode_pkg::insn_class_e insn_class;
  decode_pkg::uop_op_e     uop_code;
  logic                    off_nz; // nine-bit offset needs an address add

  insn_classify u_classify (
    .insn       (insn),
    .insn_class (insn_class),
    .uop_code   (uop_code)
  );

  assign off_nz = |insn[20:12];

  always_comb begin
    uop_count = 2'd0;
    stop = 1'b0;
    op = '{default: decode_pkg::UOP_NOP};
    dst = '{default: '0};
    src1 = '{default: '0};
    src2 = '{default: '0};
    imm = '{default: '0};
    valb_sel = '{default: 1'b0};
    mem_read = '{default: 1'b0};
    mem_write = '{default: 1'b0};
    w_enable = '{default: 1'b0};
    tx_begin = '{default: 1'b0};
    tx_end = '{default: 1'b0};
    pc_out = '{default: pc};
    case (insn_class)
      decode_pkg::CLS_ALU_IMM, decode_pkg::CLS_ALU_REG: begin
        uop_count = 2'd1;
        op[0] = uop_code;
        dst[0] = insn[4:0];
        src1[0] = insn[9:5];
        if (insn_class == decode_pkg::CLS_ALU_REG) begin
          src2[0] = insn[20:16];
          valb_sel[0] = 1'b1;
        end else begin
          imm[0] = {9'b0, insn[21:10]};
        end
        w_enable[0] = 1'b1;
        tx_begin[0] = 1'b1;
        tx_end[0] = 1'b1;
      end
      decode_pkg::CLS_MOVE: begin
        uop_count = 2'd1;
        op[0] = uop_code;
        dst[0] = insn[4:0];
        imm[0] = {5'b0, insn[20:5]};
        w_enable[0] = 1'b1;
        tx_begin[0] = 1'b1;
        tx_end[0] = 1'b1;
      end
      decode_pkg::CLS_MEM: begin
        uop_count = off_nz ? 2'd2 : 2'd1;
        if (off_nz) begin
          op[0] = insn[20] ? decode_pkg::UOP_SUB : decode_pkg::UOP_ADD; // sign bit of offset
          dst[0] = insn[4:0];
          src1[0] = insn[9:5];
          imm[0] = {12'b0, insn[20:12]};
          w_enable[0] = 1'b1;
          tx_begin[0] = 1'b1;
        end
        op[off_nz] = uop_code;
        dst[off_nz] = insn[4:0];
        src1[off_nz] = off_nz ? insn[4:0] : insn[9:5]; // address already in rt
        mem_read[off_nz] = uop_code == decode_pkg::UOP_LOAD;
        mem_write[off_nz] = uop_code == decode_pkg::UOP_STORE;
        w_enable[off_nz] = uop_code == decode_pkg::UOP_LOAD;
        tx_begin[off_nz] = !off_nz;
        tx_end[off_nz] = 1'b1;
      end
      decode_pkg::CLS_BRANCH: stop = 1'b1;
      decode_pkg::CLS_HLT: begin
        uop_count = 2'd1;
        op[0] = uop_code;
        tx_begin[0] = 1'b1;
        tx_end[0] = 1'b1;
      end
      default: ; // nop and unknown words
    endcase
  end

endmodule

/* hdl/uop_compact.sv */
`timescale 1ns/10ps

module uop_compact (
  input  decode_pkg::uop_op_e  lane_op        [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN],
  input  decode_pkg::reg_idx_t lane_dst       [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN],
  input  decode_pkg::reg_idx_t lane_src1      [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN],
  input  decode_pkg::reg_idx_t lane_src2      [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN],
  input  decode_pkg::imm_t     lane_imm       [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN],
  input  logic                 lane_valb_sel  [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN],
  input  logic                 lane_mem_read  [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN],
  input  logic                 lane_mem_write [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN],
  input  logic                 lane_w_enable  [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN],
  input  logic                 lane_tx_begin  [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN],
  input  logic                 lane_tx_end    [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN],
  input  decode_pkg::addr_t    lane_pc        [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN],
  input  logic [1:0]           lane_count     [decode_pkg::LANES],
  input  logic                 lane_stop      [decode_pkg::LANES],
  output decode_pkg::uop_op_e  next_op        [decode_pkg::SLOTS],
  output decode_pkg::reg_idx_t next_dst       [decode_pkg::SLOTS],
  output decode_pkg::reg_idx_t next_src1      [decode_pkg::SLOTS],
  output decode_pkg::reg_idx_t next_src2      [decode_pkg::SLOTS],
  output decode_pkg::imm_t     next_imm       [decode_pkg::SLOTS],
  output logic                 next_valb_sel  [decode_pkg::SLOTS],
  output logic                 next_mem_read  [decode_pkg::SLOTS],
  output logic                 next_mem_write [decode_pkg::SLOTS],
  output logic                 next_w_enable  [decode_pkg::SLOTS],
  output logic                 next_tx_begin  [decode_pkg::SLOTS],
  output logic                 next_tx_end    [decode_pkg::SLOTS],
  output decode_pkg::addr_t    next_pc        [decode_pkg::SLOTS]
);

  always_comb begin
    decode_pkg::slot_idx_t wr; // next free slot
    logic done;
    wr = '0;
    done = 1'b0;
    next_op = '{default: decode_pkg::UOP_NOP};
    next_dst = '{default: '0};
    next_src1 = '{default: '0};
    next_src2 = '{default: '0};
    next_imm = '{default: '0};
    next_valb_sel = '{default: 1'b0};
    next_mem_read = '{default: 1'b0};
    next_mem_write = '{default: 1'b0};
    next_w_enable = '{default: 1'b0};
    next_tx_begin = '{default: 1'b0};
    next_tx_end = '{default: 1'b0};
    next_pc = '{default: '0};
    for (int l = 0; l < decode_pkg::LANES; l++) begin
      for (int u = 0; u < decode_pkg::UOPS_PER_INSN; u++) begin
        if (!done && 2'(u) < lane_count[l]) begin
          next_op[wr] = lane_op[l][u];
          next_dst[wr] = lane_dst[l][u];
          next_src1[wr] = lane_src1[l][u];
          next_src2[wr] = lane_src2[l][u];
          next_imm[wr] = lane_imm[l][u];
          next_valb_sel[wr] = lane_valb_sel[l][u];
          next_mem_read[wr] = lane_mem_read[l][u];
          next_mem_write[wr] = lane_mem_write[l][u];
          next_w_enable[wr] = lane_w_enable[l][u];
          next_tx_begin[wr] = lane_tx_begin[l][u];
          next_tx_end[wr] = lane_tx_end[l][u];
          next_pc[wr] = lane_pc[l][u];
          wr = wr + 2'd1; // wraps only after the last slot
        end
      end
      done = done | lane_stop[l]; // later lanes are on the wrong path
    end
  end

endmodule

/* hdl/decode_skid.sv */
`timescale 1ns/10ps

module decode_skid (
  input  logic                 clk_in,
  input  logic                 rst,
  input  logic                 flush,
  input  logic                 fetch_valid,
  input  logic                 exe_ready,
  input  decode_pkg::uop_op_e  next_op        [decode_pkg::SLOTS],
  input  decode_pkg::reg_idx_t next_dst       [decode_pkg::SLOTS],
  input  decode_pkg::reg_idx_t next_src1      [decode_pkg::SLOTS],
  input  decode_pkg::reg_idx_t next_src2      [decode_pkg::SLOTS],
  input  decode_pkg::imm_t     next_imm       [decode_pkg::SLOTS],
  input  logic                 next_valb_sel  [decode_pkg::SLOTS],
  input  logic                 next_mem_read  [decode_pkg::SLOTS],
  input  logic                 next_mem_write [decode_pkg::SLOTS],
  input  logic                 next_w_enable  [decode_pkg::SLOTS],
  input  logic                 next_tx_begin  [decode_pkg::SLOTS],
  input  logic                 next_tx_end    [decode_pkg::SLOTS],
  input  decode_pkg::addr_t    next_pc        [decode_pkg::SLOTS],
  output logic                 decode_ready,
  output logic                 queue_valid,
  output decode_pkg::uop_op_e  uop_op         [decode_pkg::SLOTS],
  output decode_pkg::reg_idx_t uop_dst        [decode_pkg::SLOTS],
  output decode_pkg::reg_idx_t uop_src1       [decode_pkg::SLOTS],
  output decode_pkg::reg_idx_t uop_src2       [decode_pkg::SLOTS],
  output decode_pkg::imm_t     uop_imm        [decode_pkg::SLOTS],
  output logic                 uop_valb_sel   [decode_pkg::SLOTS],
  output logic                 uop_mem_read   [decode_pkg::SLOTS],
  output logic                 uop_mem_write  [decode_pkg::SLOTS],
  output logic                 uop_w_enable   [decode_pkg::SLOTS],
  output logic                 uop_tx_begin   [decode_pkg::SLOTS],
  output logic                 uop_tx_end     [decode_pkg::SLOTS],
  output decode_pkg::addr_t    uop_pc         [decode_pkg::SLOTS]
);

  decode_pkg::skid_state_e state;

  decode_pkg::uop_op_e  hold_op        [decode_pkg::SLOTS];
  decode_pkg::reg_idx_t hold_dst       [decode_pkg::SLOTS];
  decode_pkg::reg_idx_t hold_src1      [decode_pkg::SLOTS];
  decode_pkg::reg_idx_t hold_src2      [decode_pkg::SLOTS];
  decode_pkg::imm_t     hold_imm       [decode_pkg::SLOTS];
  logic                 hold_valb_sel  [decode_pkg::SLOTS];
  logic                 hold_mem_read  [decode_pkg::SLOTS];
  logic                 hold_mem_write [decode_pkg::SLOTS];
  logic                 hold_w_enable  [decode_pkg::SLOTS];
  logic                 hold_tx_begin  [decode_pkg::SLOTS];
  logic                 hold_tx_end    [decode_pkg::SLOTS];
  decode_pkg::addr_t    hold_pc        [decode_pkg::SLOTS];

  logic accept;    // group taken from fetch this edge
  logic send_new;  // straight through to execute
  logic send_held; // buffered bundle drains
  logic park;

  assign accept = fetch_valid && decode_ready; // ready only while empty
  assign send_new = accept && exe_ready;
  assign send_held = exe_ready && state == decode_pkg::SKID_HELD;
  assign park = accept && !exe_ready;

  always_ff @(posedge clk_in) begin
    if (rst || flush) begin
      state <= decode_pkg::SKID_EMPTY;
      decode_ready <= 1'b0;
      queue_valid <= 1'b0;
    end else begin
      queue_valid <= send_new || send_held;
      if (park) begin
        state <= decode_pkg::SKID_HELD;
        decode_ready <= 1'b0;
      end else if (send_held) begin
        state <= decode_pkg::SKID_EMPTY;
        decode_ready <= 1'b1;
      end else begin
        decode_ready <= state == decode_pkg::SKID_EMPTY;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    for (int s = 0; s < decode_pkg::SLOTS; s++) begin
      if (park) begin
        hold_op[s] <= next_op[s];
        hold_dst[s] <= next_dst[s];
        hold_src1[s] <= next_src1[s];
        hold_src2[s] <= next_src2[s];
        hold_imm[s] <= next_imm[s];
        hold_valb_sel[s] <= next_valb_sel[s];
        hold_mem_read[s] <= next_mem_read[s];
        hold_mem_write[s] <= next_mem_write[s];
        hold_w_enable[s] <= next_w_enable[s];
        hold_tx_begin[s] <= next_tx_begin[s];
        hold_tx_end[s] <= next_tx_end[s];
        hold_pc[s] <= next_pc[s];
      end
      if (!rst && !flush && (send_new || send_held)) begin
        uop_op[s] <= send_held ? hold_op[s] : next_op[s];
        uop_dst[s] <= send_held ? hold_dst[s] : next_dst[s];
        uop_src1[s] <= send_held ? hold_src1[s] : next_src1[s];
        uop_src2[s] <= send_held ? hold_src2[s] : next_src2[s];
        uop_imm[s] <= send_held ? hold_imm[s] : next_imm[s];
        uop_valb_sel[s] <= send_held ? hold_valb_sel[s] : next_valb_sel[s];
        uop_mem_read[s] <= send_held ? hold_mem_read[s] : next_mem_read[s];
        uop_mem_write[s] <= send_held ? hold_mem_write[s] : next_mem_write[s];
        uop_w_enable[s] <= send_held ? hold_w_enable[s] : next_w_enable[s];
        uop_tx_begin[s] <= send_held ? hold_tx_begin[s] : next_tx_begin[s];
        uop_tx_end[s] <= send_held ? hold_tx_end[s] : next_tx_end[s];
        uop_pc[s] <= send_held ? hold_pc[s] : next_pc[s];
      end
    end
  end

endmodule

/* hdl/decode_top.sv */
`timescale 1ns/10ps

module decode_top (
  input  logic                 clk_in,
  input  logic                 rst,
  input  logic                 flush,
  input  logic                 fetch_valid,
  input  logic                 exe_ready,
  input  decode_pkg::insn_t    fetched_ops   [decode_pkg::LANES],
  input  decode_pkg::addr_t    pc,
  output logic                 decode_ready,
  output logic                 queue_valid,
  output decode_pkg::uop_op_e  uop_op        [decode_pkg::SLOTS],
  output decode_pkg::reg_idx_t uop_dst       [decode_pkg::SLOTS],
  output decode_pkg::reg_idx_t uop_src1      [decode_pkg::SLOTS],
  output decode_pkg::reg_idx_t uop_src2      [decode_pkg::SLOTS],
  output decode_pkg::imm_t     uop_imm       [decode_pkg::SLOTS],
  output logic                 uop_valb_sel  [decode_pkg::SLOTS],
  output logic                 uop_mem_read  [decode_pkg::SLOTS],
  output logic                 uop_mem_write [decode_pkg::SLOTS],
  output logic                 uop_w_enable  [decode_pkg::SLOTS],
  output logic                 uop_tx_begin  [decode_pkg::SLOTS],
  output logic                 uop_tx_end    [decode_pkg::SLOTS],
  output decode_pkg::addr_t    uop_pc        [decode_pkg::SLOTS]
);

  decode_pkg::uop_op_e  lane_op        [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN];
  decode_pkg::reg_idx_t lane_dst       [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN];
  decode_pkg::reg_idx_t lane_src1      [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN];
  decode_pkg::reg_idx_t lane_src2      [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN];
  decode_pkg::imm_t     lane_imm       [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN];
  logic                 lane_valb_sel  [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN];
  logic                 lane_mem_read  [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN];
  logic                 lane_mem_write [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN];
  logic                 lane_w_enable  [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN];
  logic                 lane_tx_begin  [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN];
  logic                 lane_tx_end    [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN];
  decode_pkg::addr_t    lane_pc        [decode_pkg::LANES][decode_pkg::UOPS_PER_INSN];
  logic [1:0]           lane_count     [decode_pkg::LANES];
  logic                 lane_stop      [decode_pkg::LANES];

  decode_pkg::uop_op_e  next_op        [decode_pkg::SLOTS];
  decode_pkg::reg_idx_t next_dst       [decode_pkg::SLOTS];
  decode_pkg::reg_idx_t next_src1      [decode_pkg::SLOTS];
  decode_pkg::reg_idx_t next_src2      [decode_pkg::SLOTS];
  decode_pkg::imm_t     next_imm       [decode_pkg::SLOTS];
  logic                 next_valb_sel  [decode_pkg::SLOTS];
  logic                 next_mem_read  [decode_pkg::SLOTS];
  logic                 next_mem_write [decode_pkg::SLOTS];
  logic                 next_w_enable  [decode_pkg::SLOTS];
  logic                 next_tx_begin  [decode_pkg::SLOTS];
  logic                 next_tx_end    [decode_pkg::SLOTS];
  decode_pkg::addr_t    next_pc        [decode_pkg::SLOTS];

  for (genvar l = 0; l < decode_pkg::LANES; l++) begin : g_lane
    insn_lane_decode u_lane (
      .insn      (fetched_ops[l]),
      .pc        (pc + decode_pkg::addr_t'(4 * l)), // lane pc
      .uop_count (lane_count[l]),
      .stop      (lane_stop[l]),
      .op        (lane_op[l]),
      .dst       (lane_dst[l]),
      .src1      (lane_src1[l]),
      .src2      (lane_src2[l]),
      .imm       (lane_imm[l]),
      .valb_sel  (lane_valb_sel[l]),
      .mem_read  (lane_mem_read[l]),
      .mem_write (lane_mem_write[l]),
      .w_enable  (lane_w_enable[l]),
      .tx_begin  (lane_tx_begin[l]),
      .tx_end    (lane_tx_end[l]),
      .pc_out    (lane_pc[l])
    );
  end

  uop_compact u_compact (.*);

  decode_skid u_skid (.*);

endmodule

/* dv/decode_sva.sv */
`timescale 1ns/10ps

module decode_sva (
  input logic                    clk_in,
  input logic                    rst,
  input logic                    flush,
  input logic                    fetch_valid,
  input logic                    exe_ready,
  input logic                    decode_ready,
  input logic                    queue_valid,
  input decode_pkg::skid_state_e state
);

  // parked group with execute still stalled cannot be delivered yet
  no_early_delivery: assert property (@(posedge clk_in) disable iff (rst)
    (fetch_valid && decode_ready && !exe_ready) ##1 !exe_ready |=> !queue_valid)
    else $error("bundle delivered while execute was stalled");

  held_blocks_fetch: assert property (@(posedge clk_in) disable iff (rst)
    state == decode_pkg::SKID_HELD |-> !decode_ready)
    else $error("decode_ready high with a held bundle");

  quiet_after_clear: assert property (@(posedge clk_in)
    (rst || flush) |=> !queue_valid)
    else $error("queue_valid high right after reset or flush");

endmodule

bind decode_skid decode_sva u_sva (.*);

/* dv/decode_tb.sv */
`timescale 1ns/10ps

module decode_tb;

  localparam int WAIT_LIMIT = 50;
  localparam int FILE_FIELDS = 7; // per slot in the case file
  localparam int FIELDS = 12;

  logic                 clk_in;
  logic                 rst;
  logic                 flush;
  logic                 fetch_valid;
  logic                 exe_ready;
  decode_pkg::insn_t    fetched_ops   [decode_pkg::LANES];
  decode_pkg::addr_t    pc;
  logic                 decode_ready;
  logic                 queue_valid;
  decode_pkg::uop_op_e  uop_op        [decode_pkg::SLOTS];
  decode_pkg::reg_idx_t uop_dst       [decode_pkg::SLOTS];
  decode_pkg::reg_idx_t uop_src1      [decode_pkg::SLOTS];
  decode_pkg::reg_idx_t uop_src2      [decode_pkg::SLOTS];
  decode_pkg::imm_t     uop_imm       [decode_pkg::SLOTS];
  logic                 uop_valb_sel  [decode_pkg::SLOTS];
  logic                 uop_mem_read  [decode_pkg::SLOTS];
  logic                 uop_mem_write [decode_pkg::SLOTS];
  logic                 uop_w_enable  [decode_pkg::SLOTS];
  logic                 uop_tx_begin  [decode_pkg::SLOTS];
  logic                 uop_tx_end    [decode_pkg::SLOTS];
  decode_pkg::addr_t    uop_pc        [decode_pkg::SLOTS];

  int          errors;
  int          tests;
  int          case_errors;
  logic        timed_out;
  logic [31:0] lfsr;
  string       case_name;
  logic [31:0] insn0;
  logic [31:0] insn1;
  logic [63:0] group_pc;
  int          mode; // 0 direct, 1 stalled, 2 flushed while held
  logic [63:0] exp_f [decode_pkg::SLOTS][FIELDS];

  decode_top uut (.*);

  always #4 clk_in = ~clk_in;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
  endfunction

  task automatic draw_stall_length(output int len);
    logic [2:0] bits;
    bits = '0;
    for (int i = 0; i < 3; i++) begin
      lfsr = lfsr_next(lfsr);
      bits = {bits[1:0], lfsr[0]};
    end
    len = int'(bits) + 1;
  endtask

  function automatic string field_name(input int f);
    case (f)
      0: return "op";
      1: return "dst";
      2: return "src1";
      3: return "imm";
      4: return "tx_begin";
      5: return "tx_end";
      6: return "pc";
      7: return "src2";
      8: return "valb_sel";
      9: return "mem_read";
      10: return "mem_write";
      default: return "w_enable";
    endcase
  endfunction

  function automatic logic is_reg_alu(input logic [31:0] word);
    case (word[31:21])
      decode_pkg::ENC_ADDS, decode_pkg::ENC_SUBS, decode_pkg::ENC_ORR,
      decode_pkg::ENC_EOR, decode_pkg::ENC_ANDS: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // fields the case file leaves out, from the format rules
  task automatic derive_extra_fields();
    decode_pkg::uop_op_e op;
    logic [31:0]         word;
    for (int s = 0; s < decode_pkg::SLOTS; s++) begin
      op = decode_pkg::uop_op_e'(exp_f[s][0][3:0]);
      word = (exp_f[s][6] == group_pc) ? insn0 : insn1; // slot pc gives the lane
      exp_f[s][7] = '0;
      exp_f[s][8] = '0;
      if (op != decode_pkg::UOP_NOP && is_reg_alu(word)) begin
        exp_f[s][7] = 64'(word[20:16]);
        exp_f[s][8] = 64'd1;
      end
      exp_f[s][9] = 64'(op == decode_pkg::UOP_LOAD);
      exp_f[s][10] = 64'(op == decode_pkg::UOP_STORE);
      exp_f[s][11] = 64'(op != decode_pkg::UOP_NOP && op != decode_pkg::UOP_HLT &&
                         op != decode_pkg::UOP_STORE);
    end
  endtask

  task automatic check_low(input string what, input logic value);
    assert (value === 1'b0) else begin
      $display("FAILED %s %s expected 0 actual %b", case_name, what, value);
      case_errors++;
    end
  endtask

  task automatic check_slots();
    logic [63:0] act [FIELDS];
    for (int s = 0; s < decode_pkg::SLOTS; s++) begin
      act[0] = 64'(uop_op[s]);
      act[1] = 64'(uop_dst[s]);
      act[2] = 64'(uop_src1[s]);
      act[3] = 64'(uop_imm[s]);
      act[4] = 64'(uop_tx_begin[s]);
      act[5] = 64'(uop_tx_end[s]);
      act[6] = uop_pc[s];
      act[7] = 64'(uop_src2[s]);
      act[8] = 64'(uop_valb_sel[s]);
      act[9] = 64'(uop_mem_read[s]);
      act[10] = 64'(uop_mem_write[s]);
      act[11] = 64'(uop_w_enable[s]);
      for (int f = 0; f < FIELDS; f++) begin
        assert (act[f] === exp_f[s][f]) else begin
          $display("FAILED %s slot %0d %s expected %h actual %h",
                   case_name, s, field_name(f), exp_f[s][f], act[f]);
          case_errors++;
        end
      end
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (decode_ready !== 1'b1 && n < WAIT_LIMIT) begin
      @(posedge clk_in);
      #1;
      n++;
    end
    if (decode_ready !== 1'b1) begin
      $display("%s: timed out waiting for decode_ready to come back", case_name);
      case_errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_delivery();
    int n;
    n = 0;
    while (queue_valid !== 1'b1 && n < WAIT_LIMIT) begin
      @(posedge clk_in);
      #1;
      n++;
    end
    if (queue_valid !== 1'b1) begin
      $display("%s: timed out waiting for queue_valid", case_name);
      case_errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic run_case();
    int stall;
    wait_ready();
    if (timed_out) return;
    fetched_ops[0] = insn0;
    fetched_ops[1] = insn1;
    pc = group_pc;
    fetch_valid = 1'b1;
    exe_ready = (mode == 0);
    @(posedge clk_in);
    #1;
    fetch_valid = 1'b0;
    if (mode != 0) begin
      draw_stall_length(stall);
      for (int i = 0; i < stall; i++) begin
        check_low("queue_valid during stall", queue_valid);
        check_low("decode_ready during stall", decode_ready);
        @(posedge clk_in);
        #1;
      end
    end
    if (mode == 2) begin
      flush = 1'b1;
      @(posedge clk_in);
      #1;
      flush = 1'b0;
      exe_ready = 1'b1;
      check_low("decode_ready after flush", decode_ready);
      for (int i = 0; i < 3; i++) begin
        check_low("queue_valid after flush", queue_valid); // held bundle is dropped
        @(posedge clk_in);
        #1;
      end
      wait_ready();
      return;
    end
    exe_ready = 1'b1;
    wait_delivery();
    if (timed_out) return;
    check_slots();
    @(posedge clk_in);
    #1;
    check_low("queue_valid repeated", queue_valid);
  endtask

  initial begin
    int    fd;
    int    code;
    string line;
    string word;
    clk_in = 1'b0;
    rst = 1'b1;
    flush = 1'b0;
    fetch_valid = 1'b0;
    exe_ready = 1'b1;
    fetched_ops[0] = '0;
    fetched_ops[1] = '0;
    pc = '0;
    errors = 0;
    tests = 0;
    timed_out = 1'b0;
    lfsr = 32'h1f02;

    case_name = "reset";
    case_errors = 0;
    for (int i = 0; i < 10; i++) begin
      @(posedge clk_in);
      #1;
      check_low("decode_ready in reset", decode_ready);
      check_low("queue_valid in reset", queue_valid);
    end
    rst = 1'b0;
    @(posedge clk_in);
    #1;
    assert (decode_ready === 1'b1) else begin
      $display("FAILED %s decode_ready after reset expected 1 actual %b",
               case_name, decode_ready);
      case_errors++;
    end
    check_low("queue_valid after reset", queue_valid);
    $display("%s %s", case_name, case_errors == 0 ? "passed" : "failed");
    errors += case_errors;
    tests++;

    fd = $fopen("dv/decode_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open dv/decode_cases.txt");
      errors++;
    end else begin
      while (!timed_out && $fscanf(fd, "%s", word) == 1) begin
        if (word[0] == "#") begin
          code = $fgets(line, fd); // rest of a comment line
        end else begin
          case_name = word;
          code = $fscanf(fd, "%h %h %h %d", insn0, insn1, group_pc, mode);
          for (int s = 0; s < decode_pkg::SLOTS; s++) begin
            for (int f = 0; f < FILE_FIELDS; f++) begin
              code += $fscanf(fd, "%h", exp_f[s][f]);
            end
          end
          if (code != 4 + decode_pkg::SLOTS * FILE_FIELDS) begin
            $display("malformed line in case file: %s", case_name);
            errors++;
          end else begin
            derive_extra_fields();
            case_errors = 0;
            run_case();
            $display("%s %s", case_name, case_errors == 0 ? "passed" : "failed");
            errors += case_errors;
            tests++;
          end
        end
      end
      $fclose(fd);
    end

    $display("tests %0d errors %0d", tests, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* dv/decode_cases.txt */
# name insn0 insn1 pc mode(0 direct, 1 stall, 2 flush while held), then per slot 0..3:
# op dst src1 imm tx_begin tx_end pc (all hex)
reset_add_orr 91001441 aa050083 1000 0 1 01 02 005 1 1 1000 4 03 04 000 1 1 1004 0 00 00 000 0 0 0 0 00 00 000 0 0 0
crack_ldur_add f84100e6 d503201f 2000 0 1 06 07 010 1 0 2000 8 06 06 000 0 1 2000 0 00 00 000 0 0 0 0 00 00 000 0 0 0
crack_sub_stur f85f8128 f800016a 3000 0 2 08 09 1f8 1 0 3000 8 08 08 000 0 1 3000 9 0a 0b 000 1 1 3004 0 00 00 000 0 0 0
branch_stop 14000010 91001441 4000 0 0 00 00 000 0 0 0 0 00 00 000 0 0 0 0 00 00 000 0 0 0 0 00 00 000 0 0 0
nop_movk d503201f f297ddec 5000 0 7 0c 00 beef 1 1 5004 0 00 00 000 0 0 0 0 00 00 000 0 0 0 0 00 00 000 0 0 0
two_cracked f84100e6 f8008041 6000 0 1 06 07 010 1 0 6000 8 06 06 000 0 1 6000 1 01 02 008 1 0 6004 9 01 01 000 0 1 6004
stall_eor_hlt ca0f01cd d4400000 7000 1 5 0d 0e 000 1 1 7000 a 00 00 000 1 1 7004 0 00 00 000 0 0 0 0 00 00 000 0 0 0
stall_sub_ands d1048e30 ea140272 8000 1 2 10 11 123 1 1 8000 3 12 13 000 1 1 8004 0 00 00 000 0 0 0 0 00 00 000 0 0 0
flush_held ab030041 d2800024 9000 2 1 01 02 000 1 1 9000 6 04 00 001 1 1 9004 0 00 00 000 0 0 0 0 00 00 000 0 0 0
after_flush eb0700c5 14000010 a000 0 2 05 06 000 1 1 a000 0 00 00 000 0 0 0 0 00 00 000 0 0 0 0 00 00 000 0 0 0
unknown_movz 00000000 d2800024 b000 0 6 04 00 001 1 1 b004 0 00 00 000 0 0 0 0 00 00 000 0 0 0 0 00 00 000 0 0 0

/* files.f */
hdl/decode_pkg.sv
hdl/insn_classify.sv
hdl/insn_lane_decode.sv
hdl/uop_compact.sv
hdl/decode_skid.sv
hdl/decode_top.sv
dv/decode_sva.sv
dv/decode_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the decode testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module decode_tb -o decode_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/decode_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation PASSED" sim.log; then
  exit 0
fi
exit 1
